// ==== all.f ====
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/cpu_sm.sv
rtl/cpu_sm_outputs.sv
rtl/dma_fifo.sv
rtl/dma_top.sv
sim/clk_gen.sv
sim/dma_sva.sv
sim/dma_tb.sv

// ==== Makefile ====
TOP = dma_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== sim/dma_tb.sv ====
`timescale 1ns/1ns

module dma_tb;
    import dma_pkg::*;

    // One terminated bus cycle as seen by the memory
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        rw;
    } cycle_rec_t;

    localparam logic [31:0] A_RD = 32'h0000_1000;
    localparam logic [31:0] A_WR = 32'h0000_2000;
    localparam logic [31:0] A_BP = 32'h0000_3000;

    logic        clk;
    logic        rst_n;
    logic        reg_wr;
    reg_addr_e   reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        push;
    logic [31:0] push_data;
    logic        pop;
    logic [31:0] pop_data;
    logic [3:0]  fifo_count;
    logic        breq;
    logic        bgack;
    logic        as;
    logic        ds;
    logic        rw;
    logic [31:0] bus_addr;
    logic [31:0] bus_dout;
    logic        bgrant;
    logic        dsack;
    logic        sterm;
    logic [31:0] bus_din;

    integer      seed = 32'hafca;
    cycle_rec_t  log_q[$];
    logic [31:0] sent_q[$];
    logic [31:0] mem_store[logic [31:0]];
    logic [31:0] exp_base = '0;
    logic        exp_rw = 1'b1;
    int          xfer_id = 0;
    int          cycles_seen = 0;

    clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    dma_top dma_top_i (.*);

    // Memory content returned by reads
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        step();
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        reg_addr = addr;
        step();
        data = reg_rdata;
    endtask

    task automatic push_next_word();
        logic [31:0] word;
        word = 32'hc0de_0000 + 32'(sent_q.size() * 32'h0101);
        sent_q.push_back(word);
        push      = 1'b1;
        push_data = word;
        step();
        push = 1'b0;
    endtask

    task automatic wait_status(input int bit_idx, input string what);
        logic [31:0] rd;
        int          t;
        rd = '0;
        t  = 0;
        while (rd[bit_idx] !== 1'b1 && t < 300) begin
            reg_read(REG_STATUS, rd);
            t++;
        end
        if (rd[bit_idx] !== 1'b1) begin
            abort_run($sformatf("timeout waiting for the %s status bit", what));
        end
    endtask

    task automatic check_mem(input logic [31:0] addr, input logic [31:0] exp);
        check_val("memory written", 32'(mem_store.exists(addr)), 32'd1);
        check_val("memory word", mem_store[addr], exp);
    endtask

    // Memory model with random grant delay and random termination kind and delay
    initial begin : bus_memory
        int         gnt_cnt;
        int         term_cnt;
        logic       in_cycle;
        logic       term_sent;
        cycle_rec_t rec;
        gnt_cnt   = -1;
        term_cnt  = 0;
        in_cycle  = 1'b0;
        term_sent = 1'b0;
        rec       = '0;
        bgrant    = 1'b0;
        dsack     = 1'b0;
        sterm     = 1'b0;
        bus_din   = '0;
        forever begin
            @(posedge clk);
            #2;
            dsack = 1'b0;
            sterm = 1'b0;
            if (bgrant) begin
                if (!breq && !bgack) begin
                    bgrant = 1'b0;
                end
            end else if (breq) begin
                if (gnt_cnt < 0) begin
                    gnt_cnt = rand_below(6);
                end
                if (gnt_cnt == 0) begin
                    bgrant  = 1'b1;
                    gnt_cnt = -1;
                end else begin
                    gnt_cnt--;
                end
            end
            if (as !== 1'b1) begin
                in_cycle = 1'b0;
            end else if (ds && !in_cycle) begin
                in_cycle  = 1'b1;
                term_sent = 1'b0;
                term_cnt  = rand_below(4);
                rec.addr  = bus_addr;
                rec.rw    = rw;
                if (rw) begin
                    bus_din  = mem_word(bus_addr);
                    rec.data = bus_din;
                end else begin
                    rec.data = bus_dout;
                end
            end
            if (in_cycle && !term_sent) begin
                if (term_cnt == 0) begin
                    if (rand_below(2) == 0) begin
                        dsack = 1'b1;
                    end else begin
                        sterm = 1'b1;
                    end
                    term_sent = 1'b1;
                    if (!rec.rw) begin
                        check_val("write address reuse", 32'(mem_store.exists(rec.addr)), 32'd0);
                        mem_store[rec.addr] = rec.data;
                    end
                    log_q.push_back(rec);
                end else begin
                    term_cnt--;
                end
            end
        end
    end

    // Compare process over the cycle log
    initial begin : cycle_compare
        cycle_rec_t  rec;
        logic [31:0] next_addr;
        int          cur_id;
        int          widx;
        next_addr = '0;
        cur_id    = 0;
        widx      = 0;
        forever begin
            @(posedge clk);
            #4;
            while (cycles_seen < log_q.size()) begin
                rec = log_q[cycles_seen];
                if (cur_id != xfer_id) begin
                    cur_id    = xfer_id;
                    next_addr = exp_base;
                end
                $display("bus cycle %0d: rw %0d addr %h data %h",
                         cycles_seen, rec.rw, rec.addr, rec.data);
                check_val("bus_addr", rec.addr, next_addr);
                check_val("rw", 32'(rec.rw), 32'(exp_rw));
                if (!rec.rw) begin
                    if (widx >= sent_q.size()) begin
                        abort_run("write cycle seen with no pushed word pending");
                    end else begin
                        check_val("bus_dout", rec.data, sent_q[widx]);
                    end
                    widx++;
                end
                next_addr = next_addr + 32'd4;
                cycles_seen++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rd;
        int          base;
        int          k;
        int          t;
        reg_wr    = 1'b0;
        reg_addr  = REG_ADDR;
        reg_wdata = '0;
        push      = 1'b0;
        push_data = '0;
        pop       = 1'b0;
        t = 0;
        while (rst_n !== 1'b1 && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        step();

        // Idle bus after reset
        check_val("breq", 32'(breq), 32'd0);
        check_val("bgack", 32'(bgack), 32'd0);
        check_val("as", 32'(as), 32'd0);
        check_val("ds", 32'(ds), 32'd0);
        check_val("rw", 32'(rw), 32'd1);
        check_val("fifo_count", 32'(fifo_count), 32'd0);
        reg_read(REG_STATUS, rd);
        check_val("status", rd, 32'd0);

        reg_write(REG_ADDR, A_RD);
        reg_write(REG_COUNT, 32'd6);
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_ADDR, rd);
        check_val("addr reg", rd, A_RD);
        reg_read(REG_COUNT, rd);
        check_val("count reg", rd, 32'd6);
        reg_read(REG_CTRL, rd);
        check_val("ctrl reg", rd, 32'd1);

        // Memory to FIFO, six words
        exp_base = A_RD;
        exp_rw   = 1'b1;
        xfer_id++;
        reg_write(REG_CTRL, 32'd3);
        wait_status(0, "busy");
        reg_write(REG_ADDR, 32'hdead_0000);
        reg_read(REG_ADDR, rd);
        check_val("addr reg while busy", rd, A_RD);
        wait_status(1, "done");
        reg_read(REG_STATUS, rd);
        check_val("status", rd, 32'h2);
        check_val("cycles", 32'(cycles_seen), 32'd6);
        check_val("fifo_count", 32'(fifo_count), 32'd6);
        for (k = 0; k < 6; k++) begin
            check_val("pop_data", pop_data, mem_word(A_RD + 32'(4 * k)));
            pop = 1'b1;
            step();
            pop = 1'b0;
        end
        check_val("fifo_count", 32'(fifo_count), 32'd0);

        // FIFO to memory, five pushed words
        base = cycles_seen;
        for (k = 0; k < 5; k++) begin
            push_next_word();
        end
        check_val("fifo_count", 32'(fifo_count), 32'd5);
        exp_base = A_WR;
        exp_rw   = 1'b0;
        xfer_id++;
        reg_write(REG_ADDR, A_WR);
        reg_write(REG_COUNT, 32'd5);
        reg_write(REG_CTRL, 32'd2);
        wait_status(1, "done");
        check_val("cycles", 32'(cycles_seen), 32'(base + 5));
        check_val("fifo_count", 32'(fifo_count), 32'd0);
        for (k = 0; k < 5; k++) begin
            check_mem(A_WR + 32'(4 * k), sent_q[k]);
        end

        // Back-pressure holds the bus idle until a word arrives
        base     = cycles_seen;
        exp_base = A_BP;
        xfer_id++;
        reg_write(REG_ADDR, A_BP);
        reg_write(REG_COUNT, 32'd3);
        reg_write(REG_CTRL, 32'd2);
        t = 0;
        while (bgack !== 1'b1 && t < 50) begin
            step();
            t++;
        end
        if (bgack !== 1'b1) begin
            abort_run("bus was never granted for the back-pressure transfer");
        end
        for (k = 0; k < 3; k++) begin
            repeat (10) begin
                step();
                check_val("as", 32'(as), 32'd0);
                check_val("bgack", 32'(bgack), 32'd1);
            end
            check_val("cycles", 32'(cycles_seen), 32'(base + k));
            push_next_word();
            t = 0;
            while (cycles_seen < base + k + 1 && t < 50) begin
                step();
                t++;
            end
            if (cycles_seen < base + k + 1) begin
                abort_run("pushed word did not start a bus cycle");
            end
            t = 0;
            while (as !== 1'b0 && t < 20) begin
                step();
                t++;
            end
            if (as !== 1'b0) begin
                abort_run("address strobe stayed high after the cycle ended");
            end
        end
        wait_status(1, "done");
        check_val("cycles", 32'(cycles_seen), 32'(base + 3));
        for (k = 0; k < 3; k++) begin
            check_mem(A_BP + 32'(4 * k), sent_q[5 + k]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sim/dma_sva.sv ====
`timescale 1ns/1ns

module dma_sva (
    input logic clk,
    input logic rst_n,
    input logic breq,
    input logic bgack,
    input logic bgrant,
    input logic as,
    input logic ds
);

    // Address strobe only while the bus is owned
    as_needs_bgack: assert property (
        @(posedge clk) disable iff (!rst_n) as |-> bgack
    ) else $error("as high without bgack");

    ds_inside_as: assert property (
        @(posedge clk) disable iff (!rst_n) ds |-> as
    ) else $error("ds high while as is low");

    // Acknowledge follows a grant sampled on the previous edge
    bgack_after_grant: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(bgack) |-> $past(bgrant)
    ) else $error("bgack rose without bgrant");

    breq_released: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(bgack) |=> !breq
    ) else $error("breq still high after bgack rose");

endmodule

bind dma_top dma_sva dma_sva_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .breq   (breq),
    .bgack  (bgack),
    .bgrant (bgrant),
    .as     (as),
    .ds     (ds)
);

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held low over three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== rtl/dma_top.sv ====
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   reg_wr,
    input  dma_pkg::reg_addr_e     reg_addr,
    input  logic [31:0]            reg_wdata,
    output logic [31:0]            reg_rdata,
    input  logic                   push,
    input  logic [`DMA_DATA_W-1:0] push_data,
    input  logic                   pop,
    output logic [`DMA_DATA_W-1:0] pop_data,
    output logic [3:0]             fifo_count,
    output logic                   breq,
    output logic                   bgack,
    output logic                   as,
    output logic                   ds,
    output logic                   rw,
    output logic [`DMA_ADDR_W-1:0] bus_addr,
    output logic [`DMA_DATA_W-1:0] bus_dout,
    input  logic                   bgrant,
    input  logic                   dsack,
    input  logic                   sterm,
    input  logic [`DMA_DATA_W-1:0] bus_din
);
    import dma_pkg::*;

    dma_cfg_t               cfg;
    cpu_state_e             state;
    bus_ctrl_t              bus_ctrl;
    fifo_ctrl_t             fifo_ctrl;
    logic                   busy;
    logic                   xfer_done;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic [`DMA_DATA_W-1:0] fifo_head;

    dma_regs dma_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .busy      (busy),
        .xfer_done (xfer_done),
        .cfg       (cfg)
    );

    cpu_sm cpu_sm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .bgrant     (bgrant),
        .dsack      (dsack),
        .sterm      (sterm),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .state      (state),
        .bus_addr   (bus_addr),
        .busy       (busy),
        .xfer_done  (xfer_done)
    );

    cpu_sm_outputs cpu_sm_outputs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .dir       (cfg.dir),
        .dsack     (dsack),
        .sterm     (sterm),
        .bus       (bus_ctrl),
        .fifo_ctrl (fifo_ctrl)
    );

    dma_fifo dma_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (fifo_head),
        .inc       (fifo_ctrl.inc),
        .inc_data  (bus_din),
        .dec       (fifo_ctrl.dec),
        .count     (fifo_count),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    // FIFO head feeds both the local port and the bus
    assign pop_data = fifo_head;
    assign bus_dout = fifo_head;

    assign breq  = bus_ctrl.breq;
    assign bgack = bus_ctrl.bgack;
    assign as    = bus_ctrl.as;
    assign ds    = bus_ctrl.ds;
    assign rw    = bus_ctrl.rw;

endmodule

// ==== rtl/dma_fifo.sv ====
`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic [`DMA_DATA_W-1:0] push_data,
    input  logic                   pop,
    output logic [`DMA_DATA_W-1:0] pop_data,
    input  logic                   inc,
    input  logic [`DMA_DATA_W-1:0] inc_data,
    input  logic                   dec,
    output logic [3:0]             count,
    output logic                   full,
    output logic                   empty
);
    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`DMA_DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   wr_en;
    logic                   rd_en;
    logic [`DMA_DATA_W-1:0] wr_data;

    assign full  = (count == 4'(DEPTH));
    assign empty = (count == 4'd0);

    // Either side may fill or drain, never both at once
    assign wr_en   = (push | inc) & ~full;
    assign rd_en   = (pop | dec) & ~empty;
    assign wr_data = inc ? inc_data : push_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + 4'(wr_en) - 4'(rd_en);
        end
    end

    assign pop_data = mem[rd_ptr];

endmodule

// ==== rtl/cpu_sm_outputs.sv ====
`timescale 1ns/1ns

module cpu_sm_outputs (
    input  logic                clk,
    input  logic                rst_n,
    input  dma_pkg::cpu_state_e state,
    input  logic                dir,
    input  logic                dsack,
    input  logic                sterm,
    output dma_pkg::bus_ctrl_t  bus,
    output dma_pkg::fifo_ctrl_t fifo_ctrl
);
    import dma_pkg::*;

    // Idle bus with strobes low and a read cycle type
    localparam bus_ctrl_t BUS_RESET = '{
        breq:     1'b0,
        bgack:    1'b0,
        as:       1'b0,
        ds:       1'b0,
        rw:       1'b1,
        latch_in: 1'b0
    };

    logic      s_req;
    logic      s_own;
    logic      s_addr;
    logic      s_data;
    logic      s_sync;
    logic      owned;
    logic      data_wait;
    logic      data_sterm;
    logic      data_dsack;
    logic      term;
    bus_ctrl_t bus_next;

    assign s_req  = (state == ST_REQ);
    assign s_own  = (state == ST_OWN);
    assign s_addr = (state == ST_ADDR);
    assign s_data = (state == ST_DATA);
    assign s_sync = (state == ST_SYNC);
    assign owned  = s_own | s_addr | s_data | s_sync;

    // Data phase split by termination qualifier
    assign data_wait  = s_data & ~sterm & ~dsack;
    assign data_sterm = s_data & sterm;
    assign data_dsack = s_data & dsack & ~sterm;

    // Edge on which the word moves
    assign term = data_sterm | s_sync;

    always_comb begin
        bus_next.breq  = s_req;
        bus_next.bgack = owned;
        // Strobes held through the terminating edge and dropped one edge later
        bus_next.as = s_addr | data_wait | data_sterm | data_dsack | s_sync;
        bus_next.ds = data_wait | data_sterm | data_dsack | s_sync;
        // Write cycles only while the bus is ours
        bus_next.rw       = dir | ~owned;
        bus_next.latch_in = dir & (s_data | s_sync);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus <= BUS_RESET;
        end else begin
            bus <= bus_next;
        end
    end

    assign fifo_ctrl.inc = dir & term;
    assign fifo_ctrl.dec = ~dir & term;

endmodule

// ==== rtl/cpu_sm.sv ====
`timescale 1ns/1ns
`include "dma_defs.svh"

module cpu_sm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dma_pkg::dma_cfg_t      cfg,
    input  logic                   bgrant,
    input  logic                   dsack,
    input  logic                   sterm,
    input  logic                   fifo_full,
    input  logic                   fifo_empty,
    output dma_pkg::cpu_state_e    state,
    output logic [`DMA_ADDR_W-1:0] bus_addr,
    output logic                   busy,
    output logic                   xfer_done
);
    import dma_pkg::*;

    localparam int ADDR_W = `DMA_ADDR_W;

    cpu_state_e  state_next;
    logic [15:0] count_q;
    logic        room;
    logic        cycle_end;
    logic        last_word;

    // A read needs a free entry and a write needs a word
    assign room = cfg.dir ? !fifo_full : !fifo_empty;

    // Cycle ends on sterm in the data phase or after the dsack sync cycle
    assign cycle_end = ((state == ST_DATA) && sterm) || (state == ST_SYNC);
    assign last_word = (count_q == 16'd1);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cfg.start && (cfg.count != 16'd0)) begin
                    state_next = ST_REQ;
                end
            end
            ST_REQ: begin
                if (bgrant) begin
                    state_next = ST_OWN;
                end
            end
            ST_OWN: begin
                if (room) begin
                    state_next = ST_ADDR;
                end
            end
            ST_ADDR: state_next = ST_DATA;
            ST_DATA: begin
                // sterm wins if both arrive together
                if (sterm) begin
                    state_next = last_word ? ST_REL : ST_OWN;
                end else if (dsack) begin
                    state_next = ST_SYNC;
                end
            end
            ST_SYNC: state_next = last_word ? ST_REL : ST_OWN;
            ST_REL:  state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            bus_addr <= '0;
            count_q  <= '0;
        end else begin
            state <= state_next;
            if ((state == ST_IDLE) && cfg.start) begin
                bus_addr <= cfg.addr;
                count_q  <= cfg.count;
            end else if (cycle_end) begin
                // Next long word
                bus_addr <= bus_addr + ADDR_W'(4);
                count_q  <= count_q - 16'd1;
            end
        end
    end

    assign busy      = (state != ST_IDLE);
    assign xfer_done = (state == ST_REL);

endmodule

// ==== rtl/dma_regs.sv ====
`timescale 1ns/1ns

module dma_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                reg_wr,
    input  dma_pkg::reg_addr_e  reg_addr,
    input  logic [31:0]         reg_wdata,
    output logic [31:0]         reg_rdata,
    input  logic                busy,
    input  logic                xfer_done,
    output dma_pkg::dma_cfg_t   cfg
);
    import dma_pkg::*;

    logic [31:0] addr_q;
    logic [15:0] count_q;
    logic        dir_q;
    logic        start_q;
    logic        done_q;
    logic        wr_open;
    logic        start_wr;

    // Setup registers are locked while a transfer runs
    assign wr_open  = reg_wr && !busy;
    assign start_wr = wr_open && (reg_addr == REG_CTRL) && reg_wdata[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q  <= '0;
            count_q <= '0;
            dir_q   <= 1'b0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= start_wr;
            if (wr_open && (reg_addr == REG_ADDR)) begin
                addr_q <= reg_wdata;
            end
            if (wr_open && (reg_addr == REG_COUNT)) begin
                count_q <= reg_wdata[15:0];
            end
            if (wr_open && (reg_addr == REG_CTRL)) begin
                dir_q <= reg_wdata[0];
            end
            // Sticky done flag cleared by a new start
            if (start_wr) begin
                done_q <= 1'b0;
            end else if (xfer_done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            REG_ADDR:   reg_rdata = addr_q;
            REG_COUNT:  reg_rdata = {16'd0, count_q};
            REG_CTRL:   reg_rdata = {30'd0, start_q, dir_q};
            REG_STATUS: reg_rdata = {30'd0, done_q, busy};
            default:    reg_rdata = '0;
        endcase
    end

    assign cfg.addr  = addr_q;
    assign cfg.count = count_q;
    assign cfg.dir   = dir_q;
    assign cfg.start = start_q;

endmodule

// ==== rtl/dma_pkg.sv ====
`include "dma_defs.svh"

package dma_pkg;

    // Bus cycle sequencer states
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_REQ  = 3'd1,
        ST_OWN  = 3'd2,
        ST_ADDR = 3'd3,
        ST_DATA = 3'd4,
        ST_SYNC = 3'd5,
        ST_REL  = 3'd6
    } cpu_state_e;

    // Host register map
    typedef enum logic [1:0] {
        REG_ADDR   = 2'd0,
        REG_COUNT  = 2'd1,
        REG_CTRL   = 2'd2,
        REG_STATUS = 2'd3
    } reg_addr_e;

    // Transfer setup seen by the sequencer
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [15:0]            count;
        logic                   dir;    // 1 = memory to FIFO
        logic                   start;
    } dma_cfg_t;

    // Registered bus strobes
    typedef struct packed {
        logic breq;
        logic bgack;
        logic as;
        logic ds;
        logic rw;
        logic latch_in;
    } bus_ctrl_t;

    // FIFO counter strobes from the bus side
    typedef struct packed {
        logic inc;
        logic dec;
    } fifo_ctrl_t;

endpackage

// ==== rtl/dma_defs.svh ====
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Width of a bus word and of a FIFO entry
`define DMA_DATA_W 32

// Bus address width
`define DMA_ADDR_W 32

// FIFO entries as a power of two so the pointers wrap on their own
`define DMA_FIFO_DEPTH 8

`endif
